// File: hdl/acc_pkg.sv
package acc_pkg;

   parameter int ACC_WIDTH = 8;

   typedef enum logic [3:0] {
      NOP = 4'd0,
      LDI = 4'd1,
      ADD = 4'd2,
      SUB = 4'd3,
      NOT = 4'd4,
      AND = 4'd5,
      IOR = 4'd6,
      XOR = 4'd7,
      SHL = 4'd8,
      SHR = 4'd9
   } alu_op_t; // 10 to 15 are invalid

   typedef enum logic [3:0] {
      SEQ_NOP  = 4'd0,
      SEQ_ALU  = 4'd1,
      SEQ_JMP  = 4'd2,
      SEQ_HALT = 4'd3
   } seq_op_t; // unlisted values behave as SEQ_NOP

   typedef struct packed {
      alu_op_t    alu_code;
      logic [7:0] imm;
   } alu_inst_t;

   // both forms share the top nibble
   typedef union packed {
      struct packed {
         seq_op_t    seq_op;
         alu_op_t    alu_code;
         logic [7:0] imm;
      } alu_form;
      struct packed {
         seq_op_t     seq_op;
         logic [11:0] target;
      } jump_form;
   } program_word_t;

endpackage

// File: hdl/acc_alu.sv
`timescale 1ns/1ps

module acc_alu (
   input  logic                          clock,
   input  logic                          reset,
   input  acc_pkg::alu_inst_t            inst,
   input  logic                          inst_en,
   output logic [acc_pkg::ACC_WIDTH-1:0] result,
   output logic                          error
);
   import acc_pkg::*;

   localparam logic [1:0] ST_RESET = 2'd0;
   localparam logic [1:0] ST_READY = 2'd1;
   localparam logic [1:0] ST_ERROR = 2'd2;

   logic [1:0]           state;
   logic [ACC_WIDTH-1:0] accum;

   assign result = accum;
   assign error  = (state == ST_ERROR);

   always_ff @(posedge clock) begin
      if (reset) begin
         state <= ST_RESET;
         accum <= '0;
      end else begin
         case (state)
            ST_RESET: begin
               state <= ST_READY; // inst_en ignored here
               accum <= '0;
            end
            ST_READY: begin
               if (inst_en) begin
                  case (inst.alu_code)
                     NOP: accum <= accum;
                     LDI: accum <= inst.imm;
                     ADD: accum <= accum + inst.imm; // wraps
                     SUB: accum <= accum - inst.imm;
                     NOT: accum <= ~accum;
                     AND: accum <= accum & inst.imm;
                     IOR: accum <= accum | inst.imm;
                     XOR: accum <= accum ^ inst.imm;
                     SHL: accum <= accum << 1;
                     SHR: accum <= accum >> 1;
                     default: begin
                        state <= ST_ERROR; // sticky until reset
                        accum <= '0;
                     end
                  endcase
               end
            end
            default: begin
               state <= ST_ERROR; // error and unused encoding
               accum <= '0;
            end
         endcase
      end
   end

endmodule

// File: hdl/program_rom.sv
`timescale 1ns/1ps

module program_rom #(
   parameter int ADDR_WIDTH = 8
) (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   cyc,
   input  logic                   stb,
   input  logic [ADDR_WIDTH-1:0]  adr,
   output acc_pkg::program_word_t dat,
   output logic                   ack
);

   logic [15:0] mem [0:2**ADDR_WIDTH-1];
   logic        req;

   initial begin
      $readmemh("program.hex", mem);
   end

   assign req = cyc && stb && !ack; // new request only

   always_ff @(posedge clock) begin
      if (reset) begin
         ack <= 1'b0;
      end else begin
         ack <= req; // single cycle
      end
   end

   always_ff @(posedge clock) begin
      if (req) begin
         dat <= mem[adr];
      end
   end

endmodule

// File: hdl/rom_arbiter.sv
`timescale 1ns/1ps

module rom_arbiter #(
   parameter int ADDR_WIDTH = 8
) (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   m0_cyc,
   input  logic                   m0_stb,
   input  logic [ADDR_WIDTH-1:0]  m0_adr,
   output acc_pkg::program_word_t m0_dat,
   output logic                   m0_ack,
   input  logic                   m1_cyc,
   input  logic                   m1_stb,
   input  logic [ADDR_WIDTH-1:0]  m1_adr,
   output acc_pkg::program_word_t m1_dat,
   output logic                   m1_ack,
   output logic                   s_cyc,
   output logic                   s_stb,
   output logic [ADDR_WIDTH-1:0]  s_adr,
   input  acc_pkg::program_word_t s_dat,
   input  logic                   s_ack
);

   logic busy;        // a master holds the bus
   logic owner;
   logic last_served;
   logic grant;       // master currently routed to the slave
   logic owner_cyc;

   always_comb begin
      if (busy) begin
         grant = owner;
      end else if (m0_cyc && m1_cyc) begin
         grant = ~last_served; // round robin
      end else begin
         grant = m1_cyc;
      end
   end

   assign owner_cyc = owner ? m1_cyc : m0_cyc;

   assign s_cyc = grant ? m1_cyc : m0_cyc;
   assign s_stb = grant ? m1_stb : m0_stb;
   assign s_adr = grant ? m1_adr : m0_adr;

   assign m0_ack = s_ack && !grant;
   assign m1_ack = s_ack && grant;
   assign m0_dat = grant ? '0 : s_dat;
   assign m1_dat = grant ? s_dat : '0;

   always_ff @(posedge clock) begin
      if (reset) begin
         busy        <= 1'b0;
         owner       <= 1'b0;
         last_served <= 1'b1; // m0 wins the first tie
      end else if (busy) begin
         if (!owner_cyc) begin
            busy        <= 1'b0;
            last_served <= owner;
         end
      end else if (m0_cyc || m1_cyc) begin
         busy  <= 1'b1;
         owner <= grant;
      end
   end

endmodule

// File: hdl/instr_sequencer.sv
`timescale 1ns/1ps

module instr_sequencer #(
   parameter int ADDR_WIDTH = 8,
   parameter int START_ADDR = 0
) (
   input  logic                   clock,
   input  logic                   reset,
   output logic                   cyc,
   output logic                   stb,
   output logic [ADDR_WIDTH-1:0]  adr,
   input  acc_pkg::program_word_t dat,
   input  logic                   ack,
   output acc_pkg::alu_inst_t     inst,
   output logic                   inst_en,
   output logic                   halted
);
   import acc_pkg::*;

   localparam logic [1:0] ST_START = 2'd0;
   localparam logic [1:0] ST_FETCH = 2'd1;
   localparam logic [1:0] ST_EXEC  = 2'd2;
   localparam logic [1:0] ST_HALT  = 2'd3;

   logic [1:0]            state;
   logic [ADDR_WIDTH-1:0] pc;
   program_word_t         word; // last fetched word

   assign cyc    = (state == ST_FETCH);
   assign stb    = (state == ST_FETCH);
   assign adr    = pc;
   assign halted = (state == ST_HALT);

   assign inst.alu_code = word.alu_form.alu_code;
   assign inst.imm      = word.alu_form.imm;
   assign inst_en       = (state == ST_EXEC) && (word.alu_form.seq_op == SEQ_ALU);

   always_ff @(posedge clock) begin
      if (reset) begin
         state <= ST_START;
         pc    <= START_ADDR[ADDR_WIDTH-1:0];
      end else begin
         case (state)
            ST_START: begin
               state <= ST_FETCH;
            end
            ST_FETCH: begin
               if (ack) begin
                  state <= ST_EXEC; // drops cyc next cycle
               end
            end
            ST_EXEC: begin
               case (word.alu_form.seq_op)
                  SEQ_JMP: begin
                     pc    <= word.jump_form.target[ADDR_WIDTH-1:0];
                     state <= ST_FETCH;
                  end
                  SEQ_HALT: begin
                     state <= ST_HALT; // for good
                  end
                  default: begin
                     pc    <= pc + 1'b1; // wraps
                     state <= ST_FETCH;
                  end
               endcase
            end
            default: begin
               state <= ST_HALT;
            end
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (state == ST_FETCH && ack) begin
         word <= dat;
      end
   end

endmodule

// File: hdl/dual_acc_top.sv
`timescale 1ns/1ps

module dual_acc_top #(
   parameter int ADDR_WIDTH = 8
) (
   input  logic                          clock,
   input  logic                          reset,
   output logic [acc_pkg::ACC_WIDTH-1:0] result_0,
   output logic [acc_pkg::ACC_WIDTH-1:0] result_1,
   output logic                          error_0,
   output logic                          error_1,
   output logic                          halted_0,
   output logic                          halted_1
);
   import acc_pkg::*;

   logic                  m0_cyc;
   logic                  m0_stb;
   logic [ADDR_WIDTH-1:0] m0_adr;
   program_word_t         m0_dat;
   logic                  m0_ack;
   logic                  m1_cyc;
   logic                  m1_stb;
   logic [ADDR_WIDTH-1:0] m1_adr;
   program_word_t         m1_dat;
   logic                  m1_ack;
   logic                  s_cyc;
   logic                  s_stb;
   logic [ADDR_WIDTH-1:0] s_adr;
   program_word_t         s_dat;
   logic                  s_ack;
   alu_inst_t             inst_0;
   alu_inst_t             inst_1;
   logic                  inst_en_0;
   logic                  inst_en_1;

   instr_sequencer #(.ADDR_WIDTH(ADDR_WIDTH), .START_ADDR(0)) u_seq_0 (
      .clock(clock), .reset(reset),
      .cyc(m0_cyc), .stb(m0_stb), .adr(m0_adr), .dat(m0_dat), .ack(m0_ack),
      .inst(inst_0), .inst_en(inst_en_0), .halted(halted_0)
   );

   instr_sequencer #(.ADDR_WIDTH(ADDR_WIDTH), .START_ADDR(128)) u_seq_1 (
      .clock(clock), .reset(reset),
      .cyc(m1_cyc), .stb(m1_stb), .adr(m1_adr), .dat(m1_dat), .ack(m1_ack),
      .inst(inst_1), .inst_en(inst_en_1), .halted(halted_1)
   );

   acc_alu u_alu_0 (
      .clock(clock), .reset(reset), .inst(inst_0), .inst_en(inst_en_0),
      .result(result_0), .error(error_0)
   );

   acc_alu u_alu_1 (
      .clock(clock), .reset(reset), .inst(inst_1), .inst_en(inst_en_1),
      .result(result_1), .error(error_1)
   );

   rom_arbiter #(.ADDR_WIDTH(ADDR_WIDTH)) u_arbiter (
      .clock(clock), .reset(reset),
      .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_adr(m0_adr), .m0_dat(m0_dat), .m0_ack(m0_ack),
      .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_adr(m1_adr), .m1_dat(m1_dat), .m1_ack(m1_ack),
      .s_cyc(s_cyc), .s_stb(s_stb), .s_adr(s_adr), .s_dat(s_dat), .s_ack(s_ack)
   );

   program_rom #(.ADDR_WIDTH(ADDR_WIDTH)) u_rom (
      .clock(clock), .reset(reset),
      .cyc(s_cyc), .stb(s_stb), .adr(s_adr), .dat(s_dat), .ack(s_ack)
   );

endmodule

// File: verif/dual_acc_assertions.sv
`timescale 1ns/1ps

module dual_acc_assertions #(
   parameter int ADDR_WIDTH = 8
) (
   input logic                  clock,
   input logic                  reset,
   input logic                  s_cyc,
   input logic                  s_stb,
   input logic [ADDR_WIDTH-1:0] s_adr,
   input logic                  s_ack
);

   ack_in_cycle: assert property (@(posedge clock) disable iff (reset) s_ack |-> s_cyc)
      else $error("slave ack raised while s_cyc is low");

   // grant may not move to the other master mid-transfer
   adr_held: assert property (@(posedge clock) disable iff (reset) s_stb && !s_ack |=> $stable(s_adr))
      else $error("slave address changed before ack");

   // request must wait for its ack
   stb_held: assert property (@(posedge clock) disable iff (reset) s_stb && !s_ack |=> s_stb)
      else $error("granted stb dropped before ack");

endmodule

bind rom_arbiter dual_acc_assertions #(.ADDR_WIDTH(ADDR_WIDTH)) u_protocol_checks (
   .clock(clock),
   .reset(reset),
   .s_cyc(s_cyc),
   .s_stb(s_stb),
   .s_adr(s_adr),
   .s_ack(s_ack)
);

// File: verif/dual_acc_tb.sv
`timescale 1ns/1ps

module dual_acc_tb;
   import acc_pkg::*;

   localparam int ADDR_WIDTH     = 8;
   localparam int STEP_LIMIT     = 500;
   localparam int TIMEOUT_CYCLES = 4000;
   localparam int STABLE_CYCLES  = 50;

   logic                 clock = 1'b0;
   logic                 reset = 1'b1;
   logic [ACC_WIDTH-1:0] result_0;
   logic [ACC_WIDTH-1:0] result_1;
   logic                 error_0;
   logic                 error_1;
   logic                 halted_0;
   logic                 halted_1;

   logic [15:0]          prog [0:2**ADDR_WIDTH-1];
   logic [ACC_WIDTH+1:0] exp_0; // {halts, error, acc}
   logic [ACC_WIDTH+1:0] exp_1;
   logic                 prev_halted_0 = 1'b0;
   logic                 prev_halted_1 = 1'b0;
   int                   runs_0 = 0;
   int                   runs_1 = 0;
   int                   checks = 0;
   int                   errors = 0;
   int                   cycle_count = 0;
   int                   restart_at;
   integer               seed;

   dual_acc_top #(.ADDR_WIDTH(ADDR_WIDTH)) uut (
      .clock(clock), .reset(reset),
      .result_0(result_0), .result_1(result_1),
      .error_0(error_0), .error_1(error_1),
      .halted_0(halted_0), .halted_1(halted_1)
   );

   always #2 clock = ~clock;

   always @(posedge clock) begin
      cycle_count++;
   end

   // walks one program, returns {halts, error, acc}
   function automatic logic [ACC_WIDTH+1:0] ref_run(input int start);
      logic [ACC_WIDTH-1:0]  acc;
      logic                  err;
      logic                  done;
      logic [ADDR_WIDTH-1:0] pc;
      logic [15:0]           w;
      int                    steps;
      acc   = '0;
      err   = 1'b0;
      done  = 1'b0;
      pc    = start[ADDR_WIDTH-1:0];
      steps = 0;
      while (!done && steps < STEP_LIMIT) begin
         w = prog[pc];
         steps++;
         if (w[15:12] == 4'd3) begin
            done = 1'b1;
         end else if (w[15:12] == 4'd2) begin
            pc = w[ADDR_WIDTH-1:0]; // low bits of the target
         end else begin
            if (w[15:12] == 4'd1 && !err) begin
               case (w[11:8])
                  4'd0: acc = acc;
                  4'd1: acc = w[7:0];
                  4'd2: acc = acc + w[7:0];
                  4'd3: acc = acc - w[7:0];
                  4'd4: acc = ~acc;
                  4'd5: acc = acc & w[7:0];
                  4'd6: acc = acc | w[7:0];
                  4'd7: acc = acc ^ w[7:0];
                  4'd8: acc = {acc[ACC_WIDTH-2:0], 1'b0};
                  4'd9: acc = {1'b0, acc[ACC_WIDTH-1:1]};
                  default: begin
                     err = 1'b1;
                     acc = '0;
                  end
               endcase
            end
            pc = pc + 1'b1;
         end
      end
      return {done, err, acc};
   endfunction

   task automatic check_value(input string what, input int got, input int want);
      checks++;
      assert (got == want) else begin
         errors++;
         $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
      end
   endtask

   task automatic hold_reset(input int cycles);
      reset = 1'b1;
      repeat (cycles) begin
         @(negedge clock);
         check_value("result_0 in reset", int'(result_0), 0);
         check_value("result_1 in reset", int'(result_1), 0);
         check_value("error_0 in reset", int'(error_0), 0);
         check_value("error_1 in reset", int'(error_1), 0);
         check_value("halted_0 in reset", int'(halted_0), 0);
         check_value("halted_1 in reset", int'(halted_1), 0);
      end
      reset = 1'b0;
   endtask

   // compare at each rising halted
   always @(negedge clock) begin
      if (reset) begin
         runs_0 = 0;
         runs_1 = 0;
      end else begin
         if (halted_0 && !prev_halted_0) begin
            runs_0++;
            check_value("result_0 at halt", int'(result_0), int'(exp_0[ACC_WIDTH-1:0]));
            check_value("error_0 at halt", int'(error_0), int'(exp_0[ACC_WIDTH]));
         end
         if (halted_1 && !prev_halted_1) begin
            runs_1++;
            check_value("result_1 at halt", int'(result_1), int'(exp_1[ACC_WIDTH-1:0]));
            check_value("error_1 at halt", int'(error_1), int'(exp_1[ACC_WIDTH]));
         end
      end
      prev_halted_0 = halted_0;
      prev_halted_1 = halted_1;
   end

   initial begin
      wait (cycle_count >= TIMEOUT_CYCLES);
      $display("Timeout: the cores did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      seed = 23;
      $readmemh("program.hex", prog);
      exp_0 = ref_run(0);
      exp_1 = ref_run(128);
      check_value("reference halt of core 0", int'(exp_0[ACC_WIDTH+1]), 1);
      check_value("reference halt of core 1", int'(exp_1[ACC_WIDTH+1]), 1);
      check_value("reference error of core 1", int'(exp_1[ACC_WIDTH]), 1);
      hold_reset(3);
      restart_at = 1 + ({$random(seed)} % 60);
      repeat (restart_at) @(negedge clock);
      hold_reset(3); // restart mid-run
      while (!(halted_0 && halted_1)) begin
         @(negedge clock);
      end
      repeat (STABLE_CYCLES) begin
         @(negedge clock);
         check_value("result_0 after halt", int'(result_0), int'(exp_0[ACC_WIDTH-1:0]));
         check_value("result_1 after halt", int'(result_1), int'(exp_1[ACC_WIDTH-1:0]));
         check_value("error_0 after halt", int'(error_0), int'(exp_0[ACC_WIDTH]));
         check_value("error_1 after halt", int'(error_1), int'(exp_1[ACC_WIDTH]));
         check_value("halted_0 after halt", int'(halted_0), 1);
         check_value("halted_1 after halt", int'(halted_1), 1);
      end
      checks++;
      assert (runs_0 == 1 && runs_1 == 1) else begin
         errors++;
         $display("after the restart core 0 halted %0d times and core 1 %0d times, not once",
                  runs_0, runs_1);
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: program.hex
// program image, one 16-bit word per line, @ lines set the word address
// word = seq_op[15:12] alu_code[11:8] imm[7:0], a jump carries its target in [11:0]
@00
1155 // LDI 55
12C0 // ADD C0, wraps
1320 // SUB 20, wraps
1400 // NOT
15FE // AND FE
16F0 // IOR F0
173C // XOR 3C
1800 // SHL, top bit lost
0000 // sequencer nop
200C // JMP 0C
1C00 // skipped, invalid code
11FF // skipped
1900 // SHR
1000 // ALU NOP
4000 // unlisted seq op
3000 // HALT
@80
1110 // LDI 10
1205 // ADD 05
1C00 // invalid code 12
1107 // no effect once in error
1300 // SUB 00
3000 // HALT

// File: dual_acc_top.f
hdl/acc_pkg.sv
hdl/acc_alu.sv
hdl/program_rom.sv
hdl/rom_arbiter.sv
hdl/instr_sequencer.sv
hdl/dual_acc_top.sv
verif/dual_acc_assertions.sv
verif/dual_acc_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f dual_acc_top.f --top-module dual_acc_tb -o dual_acc_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/dual_acc_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation PASSED"; then
   exit 0
fi
exit 1
